// File: Bender.yml
package:
  name: credit_link

sources:
  - logic/cdc_fifo_pkg.sv
  - logic/credit_sender.sv
  - logic/cdc_fifo_push_ctrl.sv
  - logic/cdc_fifo_pop_ctrl.sv
  - logic/cdc_fifo_flop_ram.sv
  - logic/credit_link_top.sv
  - target: test
    files:
      - bench/credit_link_tb.sv

// File: bench/credit_link_tb.sv
// Directed testbench for the credit-controlled CDC FIFO link.
// Both clock domains run from one clock. Each test is a task that drives the
// push and pop sides and checks the responses against a queue scoreboard.
`timescale 1ns/1ps
`default_nettype none

module credit_link_tb;

  localparam int depth        = 16;
  localparam int width        = 8;
  localparam int sync_stages  = 2;
  localparam int cnt_w        = $clog2(depth + 1);
  localparam int drive_delay  = 10;
  localparam int stream_items = 100;
  // Push cycle, write edge, synchronizer stages, then the registered pop_valid
  localparam int push_to_pop  = 2 + sync_stages;
  // Credit return after a pop, plus a full pending counter to drain
  localparam int credit_wait  = depth + 2 * sync_stages + 8;
  // Rough budget for all tests, mostly the random streaming
  localparam int test_cycles  = 400;
  localparam int max_cycles   = 10 * test_cycles;

  logic             clk;
  logic             rst;
  logic             push_valid;
  logic             push_ready;
  logic [width-1:0] push_data;
  logic [cnt_w-1:0] push_credit_count;
  logic [cnt_w-1:0] push_slots;
  logic             push_full;
  logic             pop_ready;
  logic             pop_valid;
  logic [width-1:0] pop_data;
  logic [cnt_w-1:0] pop_items;
  logic             pop_empty;
  logic [width-1:0] expected_q [$];
  int               cycle_count;
  integer           seed;

  credit_link_top #(
    .Depth        (depth),
    .Width        (width),
    .NumSyncStages(sync_stages)
  ) i_credit_link_top (
    .push_clk          (clk),
    .rst_push          (rst),
    .push_valid        (push_valid),
    .push_ready        (push_ready),
    .push_data         (push_data),
    .push_credit_count (push_credit_count),
    .push_slots        (push_slots),
    .push_full         (push_full),
    .pop_clk           (clk),
    .rst_pop           (rst),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .pop_items         (pop_items),
    .pop_empty         (pop_empty)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run went past %0d cycles", max_cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
      abort_run();
    end
  endtask

  // Outputs are sampled and inputs driven at the same point after the edge
  task automatic next_cycle();
    @(posedge clk);
    #(drive_delay);
  endtask

  // Compares the offered pop item with the oldest expected byte
  task automatic take_pop_item();
    assert (expected_q.size() > 0) else begin
      $display("pop_valid was high with no item expected");
      abort_run();
    end
    check_value("pop_data", pop_data, expected_q[0]);
    void'(expected_q.pop_front());
  endtask

  task automatic wait_credits_full();
    int waited;
    waited = 0;
    while (push_credit_count != depth && waited < credit_wait) begin
      next_cycle();
      waited++;
    end
    check_value("push_credit_count", push_credit_count, depth);
  endtask

  task automatic test_reset_state();
    int waited;
    check_value("push_ready", push_ready, 0);
    check_value("pop_valid", pop_valid, 0);
    check_value("pop_empty", pop_empty, 1);
    waited = 0;
    while (!(push_ready && push_credit_count == depth) && waited < depth + 10) begin
      next_cycle();
      waited++;
    end
    check_value("push_credit_count", push_credit_count, depth);
    check_value("push_ready", push_ready, 1);
    check_value("push_slots", push_slots, depth);
  endtask

  task automatic test_single_item();
    int latency;
    pop_ready  = 1'b0;
    push_valid = 1'b1;
    push_data  = 8'ha5;
    check_value("push_ready", push_ready, 1);
    expected_q.push_back(push_data);
    latency = 0;
    while (!pop_valid && latency < push_to_pop + 4) begin
      next_cycle();
      push_valid = 1'b0;
      latency++;
    end
    check_value("pop_valid latency", latency, push_to_pop);
    take_pop_item();
    pop_ready = 1'b1;
    next_cycle();
    pop_ready = 1'b0;
    wait_credits_full();
  endtask

  task automatic test_fill_backpressure();
    int accepted;
    int offered;
    pop_ready = 1'b0;
    accepted  = 0;
    // Keep offering well past the point where credits run out
    for (offered = 0; offered < depth + 8; offered++) begin
      push_valid = 1'b1;
      push_data  = width'($random(seed));
      if (push_ready) begin
        expected_q.push_back(push_data);
        accepted++;
      end
      next_cycle();
    end
    push_valid = 1'b0;
    check_value("accepted pushes", accepted, depth);
    check_value("push_ready", push_ready, 0);
    check_value("pop_items", pop_items, depth);
    check_value("push_full", push_full, 1);
  endtask

  task automatic test_drain();
    int popped;
    int waited;
    popped    = 0;
    waited    = 0;
    pop_ready = 1'b1;
    while (popped < depth && waited < depth + 10) begin
      if (pop_valid) begin
        take_pop_item();
        popped++;
      end
      next_cycle();
      waited++;
    end
    pop_ready = 1'b0;
    check_value("popped items", popped, depth);
    wait_credits_full();
    check_value("pop_empty", pop_empty, 1);
  endtask

  task automatic test_streaming();
    int sent;
    int received;
    sent     = 0;
    received = 0;
    while (received < stream_items) begin
      push_valid = (sent < stream_items) && (($random(seed) & 1) == 1);
      push_data  = width'($random(seed));
      pop_ready  = (($random(seed) & 1) == 1);
      if (push_valid && push_ready) begin
        expected_q.push_back(push_data);
        sent++;
      end
      if (pop_valid && pop_ready) begin
        take_pop_item();
        received++;
      end
      assert (int'(push_credit_count) + int'(pop_items) <= depth) else begin
        $display("Credits 0x%0h plus pop items 0x%0h went above the FIFO depth",
                 push_credit_count, pop_items);
        abort_run();
      end
      next_cycle();
    end
    push_valid = 1'b0;
    pop_ready  = 1'b0;
    check_value("scoreboard size", expected_q.size(), 0);
    check_value("pop_valid", pop_valid, 0);
    wait_credits_full();
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    push_valid  = 1'b0;
    push_data   = '0;
    pop_ready   = 1'b0;
    cycle_count = 0;
    seed        = 3;
    repeat (2) next_cycle();
    rst = 1'b0;
    test_reset_state();
    test_single_item();
    test_fill_backpressure();
    test_drain();
    test_streaming();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/cdc_fifo_flop_ram.sv
// Flop-based storage for the CDC FIFO.
// Written on the push clock by push control; read combinationally at the
// address given by pop control. The pointers decide which entries hold
// valid data.
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_flop_ram import cdc_fifo_pkg::*; #(
  parameter int Width = default_width,
  parameter int Depth = default_depth
) (
  input  logic                     push_clk,
  input  logic                     wr_en,
  input  logic [$clog2(Depth)-1:0] wr_addr,
  input  logic [Width-1:0]         wr_data,
  input  logic [$clog2(Depth)-1:0] rd_addr,
  output logic [Width-1:0]         rd_data
);

  logic [Width-1:0] mem [Depth];

  // Single write stage
  always_ff @(posedge push_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read crosses into the pop domain, safe because the slot is stable
  // by the time its pointer update has been synchronized
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: logic/cdc_fifo_pkg.sv
// Shared types and defaults for the credit-controlled CDC FIFO link.
// Blocks that need these definitions take them with a wildcard import
// in their module header. Top-level parameters default to the values here.
`default_nettype none

package cdc_fifo_pkg;

  // Link state of the credit sender
  typedef enum logic {
    link_reset,
    link_active
  } link_state_e;

  // Pop side, holding an offered item under back-pressure or not
  typedef enum logic {
    pop_idle,
    pop_hold
  } pop_state_e;

  // Default geometry. Depth must stay a power of two for the Gray pointers
  localparam int default_depth       = 16;
  localparam int default_width       = 8;
  localparam int default_sync_stages = 2;

  // Gray to binary on a full word, callers cast to their pointer width
  function automatic logic [31:0] gray_to_bin(input logic [31:0] gray);
    logic [31:0] bin;
    bin[31] = gray[31];
    for (int i = 30; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// File: logic/cdc_fifo_pop_ctrl.sv
// Pop-side control of the CDC FIFO.
// Synchronizes the Gray write pointer from the push domain, offers the item
// at the read pointer with a registered pop_valid, and advances on each
// pop_valid/pop_ready transfer. An offered item stays put under back-pressure.
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_pop_ctrl import cdc_fifo_pkg::*; #(
  parameter int Depth         = default_depth,
  parameter int NumSyncStages = default_sync_stages
) (
  input  logic                       pop_clk,
  input  logic                       rst,
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output logic [$clog2(Depth)-1:0]   rd_addr,
  output logic [$clog2(Depth):0]     rd_ptr_gray,
  input  logic [$clog2(Depth):0]     wr_ptr_gray,
  output logic [$clog2(Depth+1)-1:0] pop_items,
  output logic                       pop_empty
);

  localparam int AddrW = $clog2(Depth);
  localparam int PtrW  = $clog2(Depth) + 1;
  localparam int CntW  = $clog2(Depth + 1);

  logic [PtrW-1:0] wr_gray_sync [NumSyncStages];
  logic [PtrW-1:0] wr_bin_sync;
  logic [PtrW-1:0] rd_ptr_bin;
  logic [PtrW-1:0] rd_ptr_next;
  logic            pop_fire;
  logic            avail_next;
  pop_state_e      pop_state;
  pop_state_e      pop_state_next;

  // Write pointer crossing into the pop domain
  always_ff @(posedge pop_clk) begin
    if (rst) begin
      for (int i = 0; i < NumSyncStages; i++) begin
        wr_gray_sync[i] <= '0;
      end
    end else begin
      wr_gray_sync[0] <= wr_ptr_gray;
      for (int i = 1; i < NumSyncStages; i++) begin
        wr_gray_sync[i] <= wr_gray_sync[i-1];
      end
    end
  end

  assign wr_bin_sync = PtrW'(gray_to_bin(32'(wr_gray_sync[NumSyncStages-1])));

  assign pop_fire       = pop_valid && pop_ready;
  assign rd_ptr_next    = rd_ptr_bin + PtrW'(pop_fire);
  assign avail_next     = (wr_bin_sync != rd_ptr_next);
  assign pop_state_next = (pop_valid && !pop_ready) ? pop_hold : pop_idle;

  // pop_valid is registered, adding one cycle after the synchronizer
  always_ff @(posedge pop_clk) begin
    if (rst) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
      pop_valid   <= 1'b0;
      pop_state   <= pop_idle;
    end else begin
      rd_ptr_bin  <= rd_ptr_next;
      rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
      pop_valid   <= avail_next;
      pop_state   <= pop_state_next;
    end
  end

  assign rd_addr   = rd_ptr_bin[AddrW-1:0];
  assign pop_items = CntW'(wr_bin_sync - rd_ptr_bin);
  assign pop_empty = (pop_items == '0);

  // Item offered last cycle and not taken must still be offered, same slot
  a_hold_stable: assert property (
    @(posedge pop_clk) disable iff (rst)
    (pop_state == pop_hold) |-> (pop_valid && $stable(rd_addr))
  ) else $error("pop item dropped or moved under back-pressure");

endmodule

`default_nettype wire

// File: logic/cdc_fifo_push_ctrl.sv
// Push-side control of the CDC FIFO.
// Writes every link beat into the flop RAM, keeps the binary and Gray write
// pointers, and synchronizes the Gray read pointer from the pop domain.
// Freed slots go into a pending counter that returns at most one credit
// pulse per cycle. The counter starts full so the sender gets Depth credits.
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_push_ctrl import cdc_fifo_pkg::*; #(
  parameter int Width         = default_width,
  parameter int Depth         = default_depth,
  parameter int NumSyncStages = default_sync_stages
) (
  input  logic                       push_clk,
  input  logic                       rst,
  input  logic                       link_valid,
  input  logic [Width-1:0]           link_data,
  input  logic                       sender_in_reset,
  output logic                       receiver_in_reset,
  output logic                       link_credit,
  output logic                       wr_en,
  output logic [$clog2(Depth)-1:0]   wr_addr,
  output logic [Width-1:0]           wr_data,
  output logic [$clog2(Depth):0]     wr_ptr_gray,
  input  logic [$clog2(Depth):0]     rd_ptr_gray,
  output logic [$clog2(Depth+1)-1:0] push_slots,
  output logic                       push_full
);

  localparam int AddrW = $clog2(Depth);
  localparam int PtrW  = $clog2(Depth) + 1;
  localparam int CntW  = $clog2(Depth + 1);

  logic [PtrW-1:0] wr_ptr_bin;
  logic [PtrW-1:0] wr_ptr_next;
  logic [PtrW-1:0] rd_gray_sync [NumSyncStages];
  logic [PtrW-1:0] rd_bin_sync;
  logic [PtrW-1:0] rd_bin_prev;
  logic [CntW-1:0] pending;
  logic [CntW-1:0] pending_avail;
  logic            credit_issue;

  // Beats arrive only with credit, so they are written without a check
  assign wr_en       = link_valid;
  assign wr_addr     = wr_ptr_bin[AddrW-1:0];
  assign wr_data     = link_data;
  assign wr_ptr_next = wr_ptr_bin + PtrW'(link_valid);

  always_ff @(posedge push_clk) begin
    if (rst) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  // Read pointer crossing into the push domain
  always_ff @(posedge push_clk) begin
    if (rst) begin
      for (int i = 0; i < NumSyncStages; i++) begin
        rd_gray_sync[i] <= '0;
      end
    end else begin
      rd_gray_sync[0] <= rd_ptr_gray;
      for (int i = 1; i < NumSyncStages; i++) begin
        rd_gray_sync[i] <= rd_gray_sync[i-1];
      end
    end
  end

  assign rd_bin_sync = PtrW'(gray_to_bin(32'(rd_gray_sync[NumSyncStages-1])));

  // Slots freed since last cycle join the pending credits right away
  assign pending_avail = pending + CntW'(rd_bin_sync - rd_bin_prev);
  assign credit_issue  = !receiver_in_reset && !sender_in_reset && (pending_avail != '0);

  always_ff @(posedge push_clk) begin
    if (rst) begin
      receiver_in_reset <= 1'b1;
      rd_bin_prev       <= '0;
      pending           <= CntW'(Depth);
      link_credit       <= 1'b0;
    end else begin
      receiver_in_reset <= 1'b0;
      rd_bin_prev       <= rd_bin_sync;
      pending           <= pending_avail - CntW'(credit_issue);
      link_credit       <= credit_issue;
    end
  end

  // Occupancy seen from the push side lags pops by the synchronizer
  assign push_slots = CntW'(Depth) - CntW'(wr_ptr_bin - rd_bin_sync);
  assign push_full  = (push_slots == '0);

  a_no_write_when_full: assert property (
    @(posedge push_clk) disable iff (rst)
    wr_en |-> !push_full
  ) else $error("write into full FIFO");

endmodule

`default_nettype wire

// File: logic/credit_link_top.sv
// Top level of the credit-controlled link into a CDC FIFO.
// A credit sender feeds push control, which writes the flop RAM; pop control
// reads it in the pop clock domain. Pointers cross between the domains as
// Gray codes. Depth must be a power of two and NumSyncStages at least 2.
`timescale 1ns/1ps
`default_nettype none

module credit_link_top import cdc_fifo_pkg::*; #(
  parameter int Depth         = default_depth,
  parameter int Width         = default_width,
  parameter int NumSyncStages = default_sync_stages
) (
  input  logic                       push_clk,
  input  logic                       rst_push,
  input  logic                       push_valid,
  output logic                       push_ready,
  input  logic [Width-1:0]           push_data,
  output logic [$clog2(Depth+1)-1:0] push_credit_count,
  output logic [$clog2(Depth+1)-1:0] push_slots,
  output logic                       push_full,
  input  logic                       pop_clk,
  input  logic                       rst_pop,
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output logic [Width-1:0]           pop_data,
  output logic [$clog2(Depth+1)-1:0] pop_items,
  output logic                       pop_empty
);

  localparam int AddrW = $clog2(Depth);
  localparam int PtrW  = $clog2(Depth) + 1;

  logic             link_valid;
  logic [Width-1:0] link_data;
  logic             link_credit;
  logic             sender_in_reset;
  logic             receiver_in_reset;
  logic             wr_en;
  logic [AddrW-1:0] wr_addr;
  logic [Width-1:0] wr_data;
  logic [AddrW-1:0] rd_addr;
  logic [PtrW-1:0]  wr_ptr_gray;
  logic [PtrW-1:0]  rd_ptr_gray;

  credit_sender #(
    .Width(Width),
    .Depth(Depth)
  ) i_credit_sender (
    .push_clk          (push_clk),
    .rst               (rst_push),
    .push_valid        (push_valid),
    .push_ready        (push_ready),
    .push_data         (push_data),
    .link_valid        (link_valid),
    .link_data         (link_data),
    .link_credit       (link_credit),
    .sender_in_reset   (sender_in_reset),
    .receiver_in_reset (receiver_in_reset),
    .credit_count      (push_credit_count)
  );

  cdc_fifo_push_ctrl #(
    .Width        (Width),
    .Depth        (Depth),
    .NumSyncStages(NumSyncStages)
  ) i_push_ctrl (
    .push_clk          (push_clk),
    .rst               (rst_push),
    .link_valid        (link_valid),
    .link_data         (link_data),
    .sender_in_reset   (sender_in_reset),
    .receiver_in_reset (receiver_in_reset),
    .link_credit       (link_credit),
    .wr_en             (wr_en),
    .wr_addr           (wr_addr),
    .wr_data           (wr_data),
    .wr_ptr_gray       (wr_ptr_gray),
    .rd_ptr_gray       (rd_ptr_gray),
    .push_slots        (push_slots),
    .push_full         (push_full)
  );

  cdc_fifo_pop_ctrl #(
    .Depth        (Depth),
    .NumSyncStages(NumSyncStages)
  ) i_pop_ctrl (
    .pop_clk     (pop_clk),
    .rst         (rst_pop),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .pop_items   (pop_items),
    .pop_empty   (pop_empty)
  );

  cdc_fifo_flop_ram #(
    .Width(Width),
    .Depth(Depth)
  ) i_flop_ram (
    .push_clk (push_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (pop_data)
  );

endmodule

`default_nettype wire

// File: logic/credit_sender.sv
// Credit sender on the push side of the link.
// Accepts ready/valid pushes and forwards each as a single valid-only beat,
// spending one credit per beat. Credits come back as one-cycle pulses from
// the receiver. While either end is in reset the credit count is held at zero.
`timescale 1ns/1ps
`default_nettype none

module credit_sender import cdc_fifo_pkg::*; #(
  parameter int Width = default_width,
  parameter int Depth = default_depth
) (
  input  logic                       push_clk,
  input  logic                       rst,
  input  logic                       push_valid,
  output logic                       push_ready,
  input  logic [Width-1:0]           push_data,
  output logic                       link_valid,
  output logic [Width-1:0]           link_data,
  input  logic                       link_credit,
  output logic                       sender_in_reset,
  input  logic                       receiver_in_reset,
  output logic [$clog2(Depth+1)-1:0] credit_count
);

  localparam int CntW = $clog2(Depth + 1);

  link_state_e link_state;

  // Link comes up one cycle after both ends have left reset
  always_ff @(posedge push_clk) begin
    if (rst) begin
      link_state      <= link_reset;
      sender_in_reset <= 1'b1;
    end else begin
      sender_in_reset <= 1'b0;
      if (receiver_in_reset || sender_in_reset) begin
        link_state <= link_reset;
      end else begin
        link_state <= link_active;
      end
    end
  end

  assign push_ready = (link_state == link_active) && (credit_count != '0);
  assign link_valid = push_valid && push_ready;
  assign link_data  = push_data;

  // A returned credit and a sent beat may land in the same cycle
  always_ff @(posedge push_clk) begin
    if (rst || (link_state == link_reset)) begin
      credit_count <= '0;
    end else begin
      credit_count <= credit_count + CntW'(link_credit) - CntW'(link_valid);
    end
  end

  a_credit_max: assert property (
    @(posedge push_clk) disable iff (rst)
    credit_count <= CntW'(Depth)
  ) else $error("credit_count above Depth");

  a_valid_has_credit: assert property (
    @(posedge push_clk) disable iff (rst)
    link_valid |-> (credit_count != '0)
  ) else $error("link_valid sent without credit");

endmodule

`default_nettype wire

// File: sim.f
logic/cdc_fifo_pkg.sv
logic/credit_sender.sv
logic/cdc_fifo_push_ctrl.sv
logic/cdc_fifo_pop_ctrl.sv
logic/cdc_fifo_flop_ram.sv
logic/credit_link_top.sv
bench/credit_link_tb.sv
